// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bus_controller
RTL_TOP   ?= bus_controller
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Test OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) +incdir+. bus_pkg.sv bus_decoder.sv \
		bank_regs.sv bus_cycle_ctrl.sv bus_controller.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bank_regs.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bank_regs (
    input  logic                 clk6x,
    input  logic                 resetn,
    input  logic                 wr_i,
    input  logic                 sel_i,
    input  logic [`BUS_DB_W-1:0] wdata_i,
    input  logic [`BUS_DB_W-1:0] mask_i,
    output logic [`BUS_DB_W-1:0] rambank_m_o,
    output logic [`BUS_DB_W-1:0] romblock_o,
    output logic [`BUS_DB_W-1:0] rdata_o
);

    logic [`BUS_DB_W-1:0] rambank_q;
    logic [`BUS_DB_W-1:0] romblock_q;

    // sel_i low is RAMBANK at 0x0000, high is ROMBANK at 0x0001
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            rambank_q  <= '0;
            // start in the boot ROM
            romblock_q <= `BUS_ROMBANK_RST;
        end
        else if (wr_i)
        begin
            if (sel_i)
                romblock_q <= wdata_i;
            else
                rambank_q <= wdata_i;
        end
    end

    // mask limits RAMBANK to the fitted SRAM size
    // registered to keep the AND off the decode path
    always_ff @(posedge clk6x)
    begin
        rambank_m_o <= rambank_q & mask_i;
    end

    assign romblock_o = romblock_q;

    // read-back shows the raw value, not the masked one
    assign rdata_o = sel_i ? romblock_q : rambank_q;

endmodule

// ==== bus_cfg.svh ====
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// widths of the CPU side of the bus

// CPU data bus, also carries the 65C816 bank byte at PHI2 rise
`define BUS_DB_W 8

// upper nibble of the CPU address, cpu_abh_i covers A15..A12
`define BUS_ABH_W 4

// widths of the memory side of the bus

// memory high address, A20..A12 towards the SRAM
`define BUS_MAH_W 9

// low address A11..A0, shared between CPU and memory
`define BUS_MAL_W 12

// full 16-bit CPU address as seen inside bank 0
`define BUS_CPU_AW 16

// decode constants

// high address driven while the boot ROM is selected
// not a real SRAM page, only a mark for the bus trace
`define BUS_BOOTROM_MARK 9'h1FF

// high byte of the I/O page at 0x9Fxx
`define BUS_IO_PAGE 8'h9F

// ROMBANK after reset, bit 7 set so the CPU starts in the boot ROM
`define BUS_ROMBANK_RST 8'h80

// extra S4H clocks requested from the phaser for ENET
// the LAN chip needs about 20 ns more access time
`define BUS_ENET_EXT 2'd1

// width of the S4H extension field
`define BUS_S4EXT_W 2

`endif

// ==== bus_controller.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_controller (
    input  logic                    clk6x,
    input  logic                    resetn,
    // phaser strobes, one clock each
    input  logic                    setup_cs_i,
    input  logic                    release_wr_i,
    input  logic                    release_cs_i,
    // CPU side
    input  logic [`BUS_ABH_W-1:0]   cpu_abh_i,
    input  logic [`BUS_MAL_W-1:0]   memcpu_abl_i,
    input  logic [`BUS_DB_W-1:0]    cpu_db_i,
    input  bus_pkg::cpu_bus_t       cpu_stat_i,
    output logic [`BUS_DB_W-1:0]    cpu_db_o,
    // memory side
    input  logic [`BUS_DB_W-1:0]    mem_db_i,
    output logic [`BUS_DB_W-1:0]    mem_db_o,
    output logic [`BUS_MAH_W-1:0]   mem_abh_o,
    output logic [`BUS_MAL_W-1:0]   memcpu_abl_o,
    output bus_pkg::mem_ctrl_t      mem_ctrl_o,
    // internal slaves
    input  logic [`BUS_DB_W-1:0]    slv_data_i,
    output bus_pkg::slv_req_t       slv_req_o,
    output logic [`BUS_CPU_AW-1:0]  slv_addr_o,
    output logic                    slv_rwn_o,
    output logic [`BUS_DB_W-1:0]    slv_datawr_o,
    output logic                    slv_datawr_valid_o,
    // from SCRB
    input  logic [`BUS_DB_W-1:0]    rambank_mask_i,
    // to phaser
    output logic [`BUS_S4EXT_W-1:0] s4_ext_o
);

    bus_pkg::cpu_addr_u   cpu_addr;
    bus_pkg::decode_t     dec;
    logic [`BUS_DB_W-1:0] rambank_m;
    logic [`BUS_DB_W-1:0] romblock;
    logic [`BUS_DB_W-1:0] bank_rdata;
    logic                 bank_wr;

    assign cpu_addr.mem.hi = cpu_abh_i;
    assign cpu_addr.mem.lo = memcpu_abl_i;

    // CPU data goes straight through on writes
    // the 65C816 bank byte is on cpu_db_i at PHI2 rise
    assign mem_db_o           = cpu_db_i;
    assign slv_datawr_o       = cpu_db_i;
    assign slv_datawr_valid_o = release_wr_i;

    bus_decoder u_decoder (
        .addr_i      (cpu_addr),
        .bank_i      (cpu_db_i),
        .stat_i      (cpu_stat_i),
        .rambank_m_i (rambank_m),
        .romblock_i  (romblock),
        .dec_o       (dec)
    );

    // register select is A0 of the captured address
    bank_regs u_bank_regs (
        .clk6x       (clk6x),
        .resetn      (resetn),
        .wr_i        (bank_wr),
        .sel_i       (slv_addr_o[0]),
        .wdata_i     (cpu_db_i),
        .mask_i      (rambank_mask_i),
        .rambank_m_o (rambank_m),
        .romblock_o  (romblock),
        .rdata_o     (bank_rdata)
    );

    bus_cycle_ctrl u_cycle_ctrl (
        .clk6x        (clk6x),
        .resetn       (resetn),
        .setup_cs_i   (setup_cs_i),
        .release_wr_i (release_wr_i),
        .release_cs_i (release_cs_i),
        .addr_i       (cpu_addr),
        .bank_i       (cpu_db_i),
        .stat_i       (cpu_stat_i),
        .dec_i        (dec),
        .mem_db_i     (mem_db_i),
        .slv_data_i   (slv_data_i),
        .bank_rdata_i (bank_rdata),
        .bank_wr_o    (bank_wr),
        .mem_abh_o    (mem_abh_o),
        .memcpu_abl_o (memcpu_abl_o),
        .mem_ctrl_o   (mem_ctrl_o),
        .slv_req_o    (slv_req_o),
        .slv_addr_o   (slv_addr_o),
        .slv_rwn_o    (slv_rwn_o),
        .s4_ext_o     (s4_ext_o),
        .cpu_db_o     (cpu_db_o)
    );

endmodule

// ==== bus_cycle_ctrl.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_cycle_ctrl (
    input  logic                    clk6x,
    input  logic                    resetn,
    input  logic                    setup_cs_i,
    input  logic                    release_wr_i,
    input  logic                    release_cs_i,
    input  bus_pkg::cpu_addr_u      addr_i,
    input  logic [`BUS_DB_W-1:0]    bank_i,
    input  bus_pkg::cpu_bus_t       stat_i,
    input  bus_pkg::decode_t        dec_i,
    input  logic [`BUS_DB_W-1:0]    mem_db_i,
    input  logic [`BUS_DB_W-1:0]    slv_data_i,
    input  logic [`BUS_DB_W-1:0]    bank_rdata_i,
    output logic                    bank_wr_o,
    output logic [`BUS_MAH_W-1:0]   mem_abh_o,
    output logic [`BUS_MAL_W-1:0]   memcpu_abl_o,
    output bus_pkg::mem_ctrl_t      mem_ctrl_o,
    output bus_pkg::slv_req_t       slv_req_o,
    output logic [`BUS_CPU_AW-1:0]  slv_addr_o,
    output logic                    slv_rwn_o,
    output logic [`BUS_S4EXT_W-1:0] s4_ext_o,
    output logic [`BUS_DB_W-1:0]    cpu_db_o
);

    // strobes and requests, owned by the phaser events
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            mem_ctrl_o <= '1;
            slv_req_o  <= '0;
            s4_ext_o   <= '0;
        end
        else
        begin
            // PHI2 rising, take the decode of this cycle
            if (setup_cs_i)
            begin
                mem_ctrl_o <= dec_i.ctrl;
                slv_req_o  <= dec_i.req;
                s4_ext_o   <= dec_i.s4_ext;
            end

            // drop wrn ahead of the chip selects for data hold
            if (release_wr_i)
                mem_ctrl_o.wrn <= 1'b1;

            // end of cycle, later events win
            if (release_cs_i)
            begin
                mem_ctrl_o <= '1;
                slv_req_o  <= '0;
            end
        end
    end

    // address and direction held for the whole cycle
    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
        begin
            mem_abh_o    <= dec_i.mem_abh;
            memcpu_abl_o <= addr_i.mem.lo;
            slv_addr_o   <= addr_i;
            slv_rwn_o    <= stat_i.rw;
        end
    end

    // CPU write data is only valid at the end of the cycle
    assign bank_wr_o = release_wr_i && slv_req_o.bankreg && !slv_rwn_o;

    // read data back to the CPU, sampled every clock
    // external read has priority over internal slaves
    always_ff @(posedge clk6x)
    begin
        if (!mem_ctrl_o.rdn)
            cpu_db_o <= mem_db_i;
        else if (slv_req_o.bankreg)
            cpu_db_o <= bank_rdata_i;
        else if (slv_req_o.bootrom || slv_req_o.scrb || slv_req_o.via1 || slv_req_o.via2)
            cpu_db_o <= slv_data_i;
    end

    // external bus is either read or written, never both
    a_rd_wr_excl: assert property (@(posedge clk6x) disable iff (!resetn)
        !(!mem_ctrl_o.rdn && !mem_ctrl_o.wrn));

    // write strobe released before the chip selects go
    a_wrn_release: assert property (@(posedge clk6x) disable iff (!resetn)
        release_wr_i |=> mem_ctrl_o.wrn);

    // a valid 65C816 cycle outside bank 0 is plain SRAM
    a_linear_sram: assert property (@(posedge clk6x) disable iff (!resetn)
        (setup_cs_i && !stat_i.cputype02 && (stat_i.vda || stat_i.sync_vpa)
            && (bank_i != '0))
        |=> (!mem_ctrl_o.sram_csn && (slv_req_o == '0)));

endmodule

// ==== bus_decoder.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_decoder (
    input  bus_pkg::cpu_addr_u         addr_i,
    input  logic [`BUS_DB_W-1:0]       bank_i,
    input  bus_pkg::cpu_bus_t          stat_i,
    input  logic [`BUS_DB_W-1:0]       rambank_m_i,
    input  logic [`BUS_DB_W-1:0]       romblock_i,
    output bus_pkg::decode_t           dec_o
);

    // strobe pattern for an external device access
    // rdn follows a read, wrn follows a write
    function automatic bus_pkg::mem_ctrl_t ext_rw(input logic rw);
        bus_pkg::mem_ctrl_t c;
        c = '1;
        c.rdn = ~rw;
        c.wrn = rw;
        return c;
    endfunction

    logic                 bank_zero;
    logic                 cyc_valid;
    logic [`BUS_ABH_W-1:0] nib;

    // a 65C02 always lives in bank 0
    assign bank_zero = stat_i.cputype02 || (bank_i == '0);

    // 65C816 with VDA and VPA both low is an internal cycle
    assign cyc_valid = stat_i.cputype02 || stat_i.vda || stat_i.sync_vpa;

    assign nib = addr_i.mem.hi;

    always_comb
    begin
        // idle decode, no strobe and no request
        dec_o = '0;
        dec_o.ctrl = '1;

        if (!cyc_valid)
        begin
            // nothing on the bus this cycle
            dec_o.ctrl = '1;
        end
        else if (bank_zero)
        begin
            if ((nib == '0) && (addr_i.mem.lo[`BUS_MAL_W-1:1] == '0))
            begin
                // 0x0000 RAMBANK, 0x0001 ROMBANK
                dec_o.req.bankreg = 1'b1;
            end
            else if (nib[3:2] == 2'b11)
            begin
                // 0xC000-0xFFFF ROM window, 16k pages
                if (romblock_i[7])
                begin
                    // boot ROM inside the FPGA, vector pulls included
                    dec_o.req.bootrom = 1'b1;
                    dec_o.mem_abh = `BUS_BOOTROM_MARK;
                end
                else
                begin
                    // ROM pages start at SRAM page 64
                    // vector pull is forced to ROM bank 0
                    if (!stat_i.vpu_n)
                        dec_o.mem_abh = {2'b01, 5'b00000, nib[1:0]};
                    else
                        dec_o.mem_abh = {2'b01, romblock_i[4:0], nib[1:0]};
                    dec_o.ctrl.sram_csn = 1'b0;
                    dec_o.ctrl.rdn = ~stat_i.rw;
                    // ROM is never written
                    dec_o.ctrl.wrn = 1'b1;
                end
            end
            else if (nib[3:1] == 3'b101)
            begin
                // 0xA000-0xBFFF RAM window, 8k pages
                // MSB inverted so bank 0 sits mid SRAM
                dec_o.mem_abh = {rambank_m_i ^ 8'h80, nib[0]};
                dec_o.ctrl = ext_rw(stat_i.rw);
                dec_o.ctrl.sram_csn = 1'b0;
            end
            else if (addr_i.io.page == `BUS_IO_PAGE)
            begin
                // I/O page, 16 bytes per slot
                case (addr_i.io.slot)
                    4'h0: dec_o.req.via1 = 1'b1;
                    4'h1: dec_o.req.via2 = 1'b1;
                    4'h2, 4'h3:
                    begin
                        // VERA takes two slots
                        dec_o.ctrl = ext_rw(stat_i.rw);
                        dec_o.ctrl.vera_csn = 1'b0;
                    end
                    4'h4:
                    begin
                        // AURA audio, external chip
                        dec_o.ctrl = ext_rw(stat_i.rw);
                        dec_o.ctrl.aio_csn = 1'b0;
                    end
                    4'h5, 4'h6: dec_o.req.scrb = 1'b1;
                    4'h8:
                    begin
                        // slow LAN chip, stretch S4H
                        dec_o.ctrl = ext_rw(stat_i.rw);
                        dec_o.ctrl.enet_csn = 1'b0;
                        dec_o.s4_ext = `BUS_ENET_EXT;
                    end
                    default: dec_o.ctrl = '1;
                endcase
            end
            else
            begin
                // remaining bank 0 space maps to low SRAM pages
                dec_o.mem_abh = {5'h00, nib};
                dec_o.ctrl = ext_rw(stat_i.rw);
                dec_o.ctrl.sram_csn = 1'b0;
            end
        end
        else
        begin
            // 65C816 outside bank 0, linear SRAM address
            dec_o.mem_abh = {bank_i[4:0], nib};
            dec_o.ctrl = ext_rw(stat_i.rw);
            dec_o.ctrl.sram_csn = 1'b0;
        end

        // the external devices share the data bus
        assert ($countones({~dec_o.ctrl.sram_csn, ~dec_o.ctrl.vera_csn,
                            ~dec_o.ctrl.aio_csn, ~dec_o.ctrl.enet_csn}) <= 1)
            else $error("decoder selected more than one chip");
    end

endmodule

// ==== bus_pkg.sv ====
`include "bus_cfg.svh"

package bus_pkg;

    // one CPU address word, decoded two ways
    // memory view picks the 4k page, I/O view picks the device slot
    typedef struct packed {
        logic [`BUS_ABH_W-1:0] hi;
        logic [`BUS_MAL_W-1:0] lo;
    } cpu_addr_mem_t;

    typedef struct packed {
        logic [7:0] page;
        logic [3:0] slot;
        logic [3:0] rsel;
    } cpu_addr_io_t;

    typedef union packed {
        cpu_addr_mem_t mem;
        cpu_addr_io_t  io;
    } cpu_addr_u;

    // CPU status pins sampled with the address
    // sync_vpa is SYNC on a 65C02 and VPA on a 65C816
    // vpu_n is the vector pull, active low
    // cputype02 high means a 65C02 is fitted
    typedef struct packed {
        logic rw;
        logic sync_vpa;
        logic vpu_n;
        logic vda;
        logic cputype02;
    } cpu_bus_t;

    // external strobes, all active low
    typedef struct packed {
        logic sram_csn;
        logic vera_csn;
        logic aio_csn;
        logic enet_csn;
        logic rdn;
        logic wrn;
    } mem_ctrl_t;

    // requests to slaves living inside the FPGA
    typedef struct packed {
        logic bootrom;
        logic scrb;
        logic via1;
        logic via2;
        logic bankreg;
    } slv_req_t;

    // everything the decoder says about one CPU cycle
    typedef struct packed {
        logic [`BUS_MAH_W-1:0]   mem_abh;
        mem_ctrl_t               ctrl;
        slv_req_t                req;
        logic [`BUS_S4EXT_W-1:0] s4_ext;
    } decode_t;

endpackage

// ==== sim.f ====
+incdir+.
bus_pkg.sv
bus_decoder.sv
bank_regs.sv
bus_cycle_ctrl.sv
bus_controller.sv
tb_bus_controller.sv

// ==== tb_bus_controller.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module tb_bus_controller;

    // one CPU cycle with its expected outcome
    typedef struct {
        logic                 cpu02;
        logic [7:0]           bank;
        logic [15:0]          addr;
        logic                 rw;
        logic                 vpu_n;
        logic                 vda;
        logic                 vpa;
        logic [7:0]           wdata;
        logic [7:0]           mem_db;
        logic [7:0]           slv;
        logic [8:0]           mah;
        logic                 chk_mah;
        bus_pkg::mem_ctrl_t   ctrl;
        bus_pkg::slv_req_t    req;
        logic [1:0]           ext;
        logic [7:0]           db;
        logic                 chk_db;
    } row_t;

    logic clk6x;
    logic resetn;
    logic setup_cs_i;
    logic release_wr_i;
    logic release_cs_i;
    logic [3:0] cpu_abh_i;
    logic [11:0] memcpu_abl_i;
    logic [7:0] cpu_db_i;
    bus_pkg::cpu_bus_t cpu_stat_i;
    logic [7:0] mem_db_i;
    logic [7:0] slv_data_i;
    logic [7:0] rambank_mask_i;
    logic [7:0] cpu_db_o;
    logic [7:0] mem_db_o;
    logic [8:0] mem_abh_o;
    logic [11:0] memcpu_abl_o;
    bus_pkg::mem_ctrl_t mem_ctrl_o;
    bus_pkg::slv_req_t slv_req_o;
    logic [15:0] slv_addr_o;
    logic slv_rwn_o;
    logic [7:0] slv_datawr_o;
    logic slv_datawr_valid_o;
    logic [1:0] s4_ext_o;

    row_t rows[$];
    integer seed;

    bus_controller dut_i (
        .clk6x              (clk6x),
        .resetn             (resetn),
        .setup_cs_i         (setup_cs_i),
        .release_wr_i       (release_wr_i),
        .release_cs_i       (release_cs_i),
        .cpu_abh_i          (cpu_abh_i),
        .memcpu_abl_i       (memcpu_abl_i),
        .cpu_db_i           (cpu_db_i),
        .cpu_stat_i         (cpu_stat_i),
        .cpu_db_o           (cpu_db_o),
        .mem_db_i           (mem_db_i),
        .mem_db_o           (mem_db_o),
        .mem_abh_o          (mem_abh_o),
        .memcpu_abl_o       (memcpu_abl_o),
        .mem_ctrl_o         (mem_ctrl_o),
        .slv_data_i         (slv_data_i),
        .slv_req_o          (slv_req_o),
        .slv_addr_o         (slv_addr_o),
        .slv_rwn_o          (slv_rwn_o),
        .slv_datawr_o       (slv_datawr_o),
        .slv_datawr_valid_o (slv_datawr_valid_o),
        .rambank_mask_i     (rambank_mask_i),
        .s4_ext_o           (s4_ext_o)
    );

    initial
    begin
        clk6x = 1'b0;
        forever #5 clk6x = ~clk6x;
    end

    task automatic abort();
        $display("Test FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_ctrl(input string name, input bus_pkg::mem_ctrl_t got,
                              input bus_pkg::mem_ctrl_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            abort();
        end
    endtask

    task automatic check_slv(input string name, input bus_pkg::slv_req_t got,
                             input bus_pkg::slv_req_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            abort();
        end
    endtask

    task automatic check_mah(input string name, input logic [8:0] got, input logic [8:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            abort();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            abort();
        end
    endtask

    task automatic check_addr(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            abort();
        end
    endtask

    // next byte of the fixed-seed random stream
    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    // sel bits are sram vera aio and enet in that order and active high
    function automatic bus_pkg::mem_ctrl_t strobes(input logic [3:0] sel, input logic rd,
                                                   input logic wr);
        bus_pkg::mem_ctrl_t c;
        c.sram_csn = ~sel[3];
        c.vera_csn = ~sel[2];
        c.aio_csn  = ~sel[1];
        c.enet_csn = ~sel[0];
        c.rdn      = ~rd;
        c.wrn      = ~wr;
        return c;
    endfunction

    // plain external access on the given chip select
    function automatic row_t ext_row(input logic cpu02, input logic [7:0] bank,
                                     input logic [15:0] addr, input logic rw,
                                     input logic [3:0] sel, input logic [8:0] mah);
        row_t r;
        r = '{cpu02: cpu02, bank: bank, addr: addr, rw: rw, vpu_n: 1'b1, vda: 1'b1,
              vpa: 1'b0, wdata: 8'h00, mem_db: 8'h00, slv: 8'h00, mah: mah, chk_mah: 1'b1,
              ctrl: strobes(sel, rw, !rw), req: '0, ext: 2'd0, db: 8'h00, chk_db: 1'b0};
        r.wdata  = rand_byte();
        r.mem_db = rand_byte();
        r.slv    = rand_byte();
        if (rw)
        begin
            r.db     = r.mem_db;
            r.chk_db = 1'b1;
        end
        return r;
    endfunction

    // internal slave access without any external strobe
    function automatic row_t slv_row(input logic [15:0] addr, input logic rw,
                                     input bus_pkg::slv_req_t req);
        row_t r;
        r = ext_row(1'b1, 8'h00, addr, rw, 4'b0000, 9'h000);
        r.ctrl    = '1;
        r.req     = req;
        r.chk_mah = 1'b0;
        r.db      = r.slv;
        r.chk_db  = rw;
        return r;
    endfunction

    // wait until the write strobe is back high
    task automatic wait_wrn_high();
        integer n;
        n = 0;
        while (mem_ctrl_o.wrn !== 1'b1)
        begin
            @(negedge clk6x);
            n = n + 1;
            if (n > 8)
            begin
                $display("timeout waiting for wrn to rise after release_wr");
                abort();
            end
        end
    endtask

    // wait until the cycle has let go of every strobe
    task automatic wait_released();
        integer n;
        n = 0;
        while ((mem_ctrl_o !== 6'h3F) || (slv_req_o !== 5'h00))
        begin
            @(negedge clk6x);
            n = n + 1;
            if (n > 8)
            begin
                $display("timeout waiting for strobes to release after release_cs");
                abort();
            end
        end
    endtask

    task automatic run_row(input row_t r);
        bus_pkg::mem_ctrl_t after_wr;
        @(negedge clk6x);
        {cpu_abh_i, memcpu_abl_i} = r.addr;
        cpu_db_i   = r.bank;
        cpu_stat_i = '{rw: r.rw, sync_vpa: r.vpa, vpu_n: r.vpu_n, vda: r.vda,
                       cputype02: r.cpu02};
        mem_db_i   = r.mem_db;
        slv_data_i = r.slv;
        setup_cs_i = 1'b1;
        @(negedge clk6x);
        setup_cs_i = 1'b0;
        // write data replaces the bank byte on the data bus
        cpu_db_i = r.wdata;
        @(negedge clk6x);
        check_ctrl("mem_ctrl_o", mem_ctrl_o, r.ctrl);
        check_slv("slv_req_o", slv_req_o, r.req);
        check_byte("s4_ext_o", {6'd0, s4_ext_o}, {6'd0, r.ext});
        if (r.chk_mah)
            check_mah("mem_abh_o", mem_abh_o, r.mah);
        if (r.chk_db)
            check_byte("cpu_db_o", cpu_db_o, r.db);
        check_addr("memcpu_abl_o", {4'd0, memcpu_abl_o}, {4'd0, r.addr[11:0]});
        check_addr("slv_addr_o", slv_addr_o, r.addr);
        check_byte("slv_rwn_o", {7'd0, slv_rwn_o}, {7'd0, r.rw});
        check_byte("mem_db_o", mem_db_o, r.wdata);
        check_byte("slv_datawr_o", slv_datawr_o, r.wdata);
        check_byte("slv_datawr_valid_o", {7'd0, slv_datawr_valid_o}, 8'h00);
        release_wr_i = 1'b1;
        #1;
        check_byte("slv_datawr_valid_o", {7'd0, slv_datawr_valid_o}, 8'h01);
        @(negedge clk6x);
        release_wr_i = 1'b0;
        wait_wrn_high();
        after_wr = r.ctrl;
        after_wr.wrn = 1'b1;
        check_ctrl("mem_ctrl_o", mem_ctrl_o, after_wr);
        release_cs_i = 1'b1;
        @(negedge clk6x);
        release_cs_i = 1'b0;
        wait_released();
        // idle gap lets the masked RAMBANK settle
        repeat (2) @(negedge clk6x);
    endtask

    initial
    begin
        #2ms;
        $display("global timeout, simulation did not finish");
        abort();
    end

    initial
    begin
        row_t r;
        logic [7:0] rb;
        logic [7:0] rom;
        logic [7:0] mask;
        bus_pkg::slv_req_t q;

        seed = 32'h8ec6_48cd;
        resetn = 1'b0;
        setup_cs_i = 1'b0;
        release_wr_i = 1'b0;
        release_cs_i = 1'b0;
        cpu_abh_i = '0;
        memcpu_abl_i = '0;
        cpu_db_i = '0;
        cpu_stat_i = '{rw: 1'b1, sync_vpa: 1'b0, vpu_n: 1'b1, vda: 1'b1, cputype02: 1'b1};
        mem_db_i = '0;
        slv_data_i = '0;
        mask = 8'h3F;
        rambank_mask_i = mask;

        // top bits set so the mask has something to clear
        rb  = rand_byte() | 8'hC0;
        // never bank 0 so the vector pull differs from a plain ROM read
        rom = (rand_byte() & 8'h1F) | 8'h01;

        // low SRAM page equals the address nibble
        rows.push_back(ext_row(1'b1, 8'h00, 16'h1234, 1'b1, 4'b1000, 9'h001));
        rows.push_back(ext_row(1'b1, 8'h00, 16'h5678, 1'b0, 4'b1000, 9'h005));
        // I/O page slots
        q = '0;
        q.via1 = 1'b1;
        rows.push_back(slv_row(16'h9F00, 1'b1, q));
        q = '0;
        q.via2 = 1'b1;
        rows.push_back(slv_row(16'h9F1A, 1'b1, q));
        r = ext_row(1'b1, 8'h00, 16'h9F20, 1'b0, 4'b0100, 9'h000);
        r.chk_mah = 1'b0;
        rows.push_back(r);
        r = ext_row(1'b1, 8'h00, 16'h9F41, 1'b1, 4'b0010, 9'h000);
        r.chk_mah = 1'b0;
        rows.push_back(r);
        q = '0;
        q.scrb = 1'b1;
        rows.push_back(slv_row(16'h9F50, 1'b1, q));
        r = ext_row(1'b1, 8'h00, 16'h9F83, 1'b1, 4'b0001, 9'h000);
        r.chk_mah = 1'b0;
        r.ext = 2'd1;
        rows.push_back(r);
        // bank registers are written and then read back
        q = '0;
        q.bankreg = 1'b1;
        r = slv_row(16'h0000, 1'b0, q);
        r.wdata = rb;
        rows.push_back(r);
        r = slv_row(16'h0001, 1'b0, q);
        r.wdata = rom;
        rows.push_back(r);
        r = slv_row(16'h0000, 1'b1, q);
        r.db = rb;
        rows.push_back(r);
        r = slv_row(16'h0001, 1'b1, q);
        r.db = rom;
        rows.push_back(r);
        // RAM window uses the masked RAMBANK with MSB flipped followed by A12
        rows.push_back(ext_row(1'b1, 8'h00, 16'hB123, 1'b1, 4'b1000,
                               {(rb & mask) ^ 8'h80, 1'b1}));
        // ROM window starts at page 64 with ROMBANK and then A13..A12
        rows.push_back(ext_row(1'b1, 8'h00, 16'hD000, 1'b1, 4'b1000, {2'b01, rom[4:0], 2'b01}));
        r = ext_row(1'b1, 8'h00, 16'hE000, 1'b0, 4'b1000, {2'b01, rom[4:0], 2'b10});
        r.ctrl = strobes(4'b1000, 1'b0, 1'b0);
        rows.push_back(r);
        r = ext_row(1'b1, 8'h00, 16'hFFFC, 1'b1, 4'b1000, {2'b01, 5'd0, 2'b11});
        r.vpu_n = 1'b0;
        rows.push_back(r);
        // ROMBANK bit 7 selects the boot ROM
        q = '0;
        q.bankreg = 1'b1;
        r = slv_row(16'h0001, 1'b0, q);
        r.wdata = 8'h80 | (rand_byte() & 8'h1F);
        rows.push_back(r);
        q = '0;
        q.bootrom = 1'b1;
        r = slv_row(16'hC010, 1'b1, q);
        r.mah = `BUS_BOOTROM_MARK;
        r.chk_mah = 1'b1;
        rows.push_back(r);
        // 65C816 linear banks and an internal cycle
        rows.push_back(ext_row(1'b0, 8'h23, 16'h4567, 1'b1, 4'b1000, 9'h034));
        // valid through VPA alone, and A000 is not the RAM window here
        r = ext_row(1'b0, 8'h11, 16'hA000, 1'b0, 4'b1000, 9'h11A);
        r.vda = 1'b0;
        r.vpa = 1'b1;
        rows.push_back(r);
        r = ext_row(1'b0, 8'h05, 16'h1000, 1'b1, 4'b0000, 9'h000);
        r.vda = 1'b0;
        r.ctrl = '1;
        r.chk_db = 1'b0;
        rows.push_back(r);

        repeat (4) @(negedge clk6x);
        resetn = 1'b1;
        @(negedge clk6x);
        check_ctrl("mem_ctrl_o", mem_ctrl_o, 6'h3F);
        check_slv("slv_req_o", slv_req_o, 5'h00);
        check_byte("s4_ext_o", {6'd0, s4_ext_o}, 8'h00);

        foreach (rows[i])
            run_row(rows[i]);

        $display("Test OK");
        $finish;
    end

endmodule
